//--- logic/obi_sec_pkg.sv
//////////////////////////////////////////////////
// Security controls and checksum rules for OBI
// achk covers a read-only address phase, so
// be = 4'b1111 and we = 0 are fixed inputs
//////////////////////////////////////////////////

package obi_sec_pkg;

  // Checksum widths
  localparam int ACHK_W = 6;
  localparam int RCHK_W = 5;

  // Security enables, static during operation
  typedef struct packed {
    logic integrity_en;  // rchk check on integrity region
    logic parity_en;     // gnt and rvalid parity checks
  } sec_ctrl_t;

  // Address phase checksum
  // Bits 3:0 even byte parity of the word address, bits 1:0 read as zero
  // Bit 4 odd parity of prot and dbg, bit 5 odd parity of be and we
  function automatic logic [ACHK_W-1:0] calc_achk(input logic [31:0] addr,
                                                  input logic [2:0]  prot,
                                                  input logic        dbg);
    return {~^{4'b1111, 1'b0}, ~^{prot, dbg},
            ^addr[31:24], ^addr[23:16], ^addr[15:8], ^{addr[7:2], 2'b00}};
  endfunction

  // Response checksum
  // Bits 3:0 even byte parity of rdata, bit 4 even parity of err
  function automatic logic [RCHK_W-1:0] calc_rchk(input logic [31:0] rdata,
                                                  input logic        err);
    return {^err, ^rdata[31:24], ^rdata[23:16], ^rdata[15:8], ^rdata[7:0]};
  endfunction

endpackage

//--- logic/obi_bus_pkg.sv
//////////////////////////////////////////////////
// OBI instruction-side channel payloads
// Read-only bus, no wdata, be, we or atop fields
// Checksum widths come from the security package
//////////////////////////////////////////////////

package obi_bus_pkg;

  import obi_sec_pkg::*;

  // prot encoding {mode[1:0], data}, machine mode instruction fetch
  localparam logic [2:0] PROT_M_FETCH = 3'b110;

  // Address phase payload
  typedef struct packed {
    logic [31:0]       addr;       // word address, bits 1:0 zero
    logic [2:0]        prot;
    logic              dbg;        // fetch issued in debug mode
    logic              integrity;  // target lies in integrity region
    logic [ACHK_W-1:0] achk;
  } obi_a_t;

  // Response channel payload
  typedef struct packed {
    logic [31:0]       rdata;
    logic              err;
    logic [RCHK_W-1:0] rchk;
  } obi_r_t;

  // Response handed to the fetch consumer
  typedef struct packed {
    logic [31:0] rdata;
    logic        err;            // bus error from slave
    logic        integrity_err;  // any parity or checksum fault on this response
    logic        integrity;      // response came from integrity region
  } instr_resp_t;

  // Adapter FSM states
  typedef enum logic {
    TRANSPARENT,  // A channel follows the request
    REGISTERED    // A channel driven from held register
  } obi_if_state_e;

  // Held A channel register after reset
  localparam obi_a_t OBI_A_RESET_VAL = '{addr: 32'h0, prot: PROT_M_FETCH, dbg: 1'b0,
                                         integrity: 1'b0, achk: '0};

endpackage

//--- logic/fetch_addr_gen.sv
//////////////////////////////////////////////////
// Sequential word fetch address generator
// Starts at address 0, use redirect to boot elsewhere
// Credits limit fetches in flight to MAX_OUTSTANDING
//////////////////////////////////////////////////
`timescale 1ns/100ps

module fetch_addr_gen import obi_bus_pkg::*; #(
  parameter int MAX_OUTSTANDING = 2
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        fetch_en_i,
  input  logic        redirect_i,
  input  logic [31:0] redirect_addr_i,
  input  logic        dbg_mode_i,
  output logic        trans_valid_o,
  input  logic        trans_ready_i,
  output obi_a_t      trans_o,
  input  logic        resp_valid_i
);

  localparam int CNT_W = $clog2(MAX_OUTSTANDING + 1);

  logic [31:0]      addr_q;
  logic [31:0]      pend_addr_q;  // redirect target parked behind a held request
  logic             pend_q;
  logic [CNT_W-1:0] credit_q;     // requests accepted and not yet answered
  logic             xfer;
  logic             held;

  // No new request once every credit is in use
  assign trans_valid_o = fetch_en_i && (credit_q < CNT_W'(MAX_OUTSTANDING));
  assign xfer          = trans_valid_o && trans_ready_i;
  // Request offered but not taken, payload must not move
  assign held          = trans_valid_o && !trans_ready_i;

  always_comb begin
    trans_o           = OBI_A_RESET_VAL;
    trans_o.addr      = {addr_q[31:2], 2'b00};
    trans_o.prot      = PROT_M_FETCH;
    trans_o.dbg       = dbg_mode_i;
    // Stand-in for the PMA, upper half of memory is protected
    trans_o.integrity = addr_q[31];
    // achk is filled in by the adapter
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q   <= 32'h0;
      pend_q   <= 1'b0;
      credit_q <= '0;
    end else begin
      // Redirect beats sequential advance, but waits for a held request
      if (redirect_i && held) begin
        pend_q <= 1'b1;
      end else if (redirect_i) begin
        addr_q <= redirect_addr_i;
        pend_q <= 1'b0;
      end else if (pend_q && !held) begin
        addr_q <= pend_addr_q;
        pend_q <= 1'b0;
      end else if (xfer) begin
        addr_q <= addr_q + 32'd4;
      end
      // Credit up on accept, down on response, both cancel out
      if (xfer && !resp_valid_i) begin
        credit_q <= credit_q + 1'b1;
      end else if (!xfer && resp_valid_i) begin
        credit_q <= credit_q - 1'b1;
      end
    end
  end

  // Parked target, only read while pend_q is set
  always_ff @(posedge clk) begin
    if (redirect_i && held) begin
      pend_addr_q <= redirect_addr_i;
    end
  end

endmodule

//--- logic/obi_integrity_fifo.sv
//////////////////////////////////////////////////
// Per-transfer attribute FIFO for OBI responses
// Assumes in-order responses and at most
// MAX_OUTSTANDING granted transfers in flight
//////////////////////////////////////////////////
`timescale 1ns/100ps

module obi_integrity_fifo import obi_bus_pkg::*, obi_sec_pkg::*; #(
  parameter int MAX_OUTSTANDING = 2
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      gntpar_err_i,
  input  logic      trans_integrity_i,
  input  sec_ctrl_t sec_ctrl_i,
  input  logic      obi_req_i,
  input  logic      obi_gnt_i,
  input  logic      obi_rvalid_i,
  input  obi_r_t    obi_r_i,
  output logic      gntpar_err_resp_o,
  output logic      integrity_resp_o,
  output logic      rchk_err_resp_o,
  output logic      protocol_err_o
);

  localparam int PTR_W = (MAX_OUTSTANDING > 1) ? $clog2(MAX_OUTSTANDING) : 1;
  localparam int CNT_W = $clog2(MAX_OUTSTANDING + 1);

  // What a response needs to know about its own request
  typedef struct packed {
    logic gntpar_err;
    logic integrity;
  } attr_t;

  attr_t             fifo_q [MAX_OUTSTANDING];
  attr_t             wr_attr;
  attr_t             head;
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [CNT_W-1:0]  cnt_q;
  logic              empty;
  logic              wr_en;
  logic              rd_en;
  logic [RCHK_W-1:0] rchk_exp;

  assign empty = (cnt_q == '0);
  // Push on address handshake, pop on response
  assign wr_en = obi_req_i && obi_gnt_i;
  assign rd_en = obi_rvalid_i && !empty;

  assign wr_attr.gntpar_err = gntpar_err_i;
  assign wr_attr.integrity  = trans_integrity_i;
  assign head               = fifo_q[rd_ptr_q];

  //////////////////////////////////////////////////
  // Response side lookups
  //////////////////////////////////////////////////

  assign rchk_exp = calc_rchk(obi_r_i.rdata, obi_r_i.err);

  // Only valid with rvalid, zero when no entry is waiting
  assign gntpar_err_resp_o = rd_en && head.gntpar_err;
  assign integrity_resp_o  = rd_en && head.integrity;
  // rchk checked only for protected targets
  assign rchk_err_resp_o   = rd_en && head.integrity && sec_ctrl_i.integrity_en &&
                             (rchk_exp != obi_r_i.rchk);
  // Response with nothing in flight
  assign protocol_err_o    = obi_rvalid_i && empty;

  //////////////////////////////////////////////////
  // Pointers and count
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(MAX_OUTSTANDING - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(MAX_OUTSTANDING - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Push and pop together leave the count alone
      if (wr_en && !rd_en) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (!wr_en && rd_en) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // Entry storage, read only when the count says it is live
  always_ff @(posedge clk) begin
    if (wr_en) begin
      fifo_q[wr_ptr_q] <= wr_attr;
    end
  end

endmodule

//--- logic/instr_obi_adapter.sv
//////////////////////////////////////////////////
// OBI instruction adapter with integrity checks
// Consumer must accept every response, no stall
// Outstanding count is limited upstream
//////////////////////////////////////////////////
`timescale 1ns/100ps

module instr_obi_adapter import obi_bus_pkg::*, obi_sec_pkg::*; #(
  parameter int MAX_OUTSTANDING = 2
) (
  input  logic        clk,
  input  logic        rst_n,
  // Fetch request side
  input  logic        trans_valid_i,
  output logic        trans_ready_o,
  input  obi_a_t      trans_i,
  // Fetch response side
  output logic        resp_valid_o,
  output instr_resp_t resp_o,
  output logic        alert_major_o,
  input  sec_ctrl_t   sec_ctrl_i,
  // OBI A channel
  output logic        obi_req_o,
  output logic        obi_reqpar_o,
  output obi_a_t      obi_a_o,
  input  logic        obi_gnt_i,
  input  logic        obi_gntpar_i,
  // OBI R channel
  input  logic        obi_rvalid_i,
  input  logic        obi_rvalidpar_i,
  input  obi_r_t      obi_r_i
);

  obi_if_state_e state_q;
  obi_if_state_e next_state;
  obi_a_t        obi_a_q;        // A channel frozen while ungranted
  logic          gntpar_err;     // immediate
  logic          rvalidpar_err;  // immediate
  logic          gntpar_err_resp;
  logic          integrity_resp;
  logic          rchk_err_resp;
  logic          protocol_err;

  //////////////////////////////////////////////////
  // A channel FSM
  //////////////////////////////////////////////////

  always_comb begin
    next_state = state_q;
    case (state_q)
      // Ungranted request must be frozen from next cycle on
      TRANSPARENT: if (obi_req_o && !obi_gnt_i) next_state = REGISTERED;
      REGISTERED:  if (obi_gnt_i) next_state = TRANSPARENT;
      default:     next_state = TRANSPARENT;
    endcase
  end

  always_comb begin
    if (state_q == TRANSPARENT) begin
      obi_req_o    = trans_valid_i;
      obi_a_o      = trans_i;
      obi_a_o.achk = calc_achk(trans_i.addr, trans_i.prot, trans_i.dbg);
    end else begin
      // Request is never retracted before gnt
      obi_req_o = 1'b1;
      obi_a_o   = obi_a_q;
    end
  end

  assign obi_reqpar_o  = !obi_req_o;
  // Held request occupies the channel, next one waits
  assign trans_ready_o = (state_q == TRANSPARENT);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= TRANSPARENT;
      obi_a_q <= OBI_A_RESET_VAL;
    end else begin
      state_q <= next_state;
      if (state_q == TRANSPARENT && next_state == REGISTERED) begin
        obi_a_q <= obi_a_o;
      end
    end
  end

  //////////////////////////////////////////////////
  // R channel and alerts
  //////////////////////////////////////////////////

  // Parity twin must always be the inverse
  assign gntpar_err    = sec_ctrl_i.parity_en && (obi_gnt_i == obi_gntpar_i);
  assign rvalidpar_err = sec_ctrl_i.parity_en && (obi_rvalid_i == obi_rvalidpar_i);

  // Responses pass straight through, zero latency
  assign resp_valid_o = obi_rvalid_i;

  always_comb begin
    resp_o.rdata         = obi_r_i.rdata;
    resp_o.err           = obi_r_i.err;
    resp_o.integrity_err = rvalidpar_err || gntpar_err_resp || rchk_err_resp;
    resp_o.integrity     = integrity_resp;
  end

  // Any fault raises the alert in the cycle it is seen
  assign alert_major_o = rchk_err_resp || rvalidpar_err || gntpar_err || protocol_err;

  // Integrity flag taken from the granted payload, not the next request
  obi_integrity_fifo #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) u_integrity_fifo (
    .clk               (clk),
    .rst_n             (rst_n),
    .gntpar_err_i      (gntpar_err),
    .trans_integrity_i (obi_a_o.integrity),
    .sec_ctrl_i        (sec_ctrl_i),
    .obi_req_i         (obi_req_o),
    .obi_gnt_i         (obi_gnt_i),
    .obi_rvalid_i      (obi_rvalid_i),
    .obi_r_i           (obi_r_i),
    .gntpar_err_resp_o (gntpar_err_resp),
    .integrity_resp_o  (integrity_resp),
    .rchk_err_resp_o   (rchk_err_resp),
    .protocol_err_o    (protocol_err)
  );

endmodule

//--- logic/instr_fetch_obi_top.sv
//////////////////////////////////////////////////
// Instruction fetch bus unit, OBI master side
// sec_ctrl_i must be static while fetching
//////////////////////////////////////////////////
`timescale 1ns/100ps

module instr_fetch_obi_top import obi_bus_pkg::*, obi_sec_pkg::*; #(
  parameter int MAX_OUTSTANDING = 2  // 1 to 4
) (
  input  logic        clk,
  input  logic        rst_n,
  // Fetch control
  input  logic        fetch_en_i,
  input  logic        redirect_i,
  input  logic [31:0] redirect_addr_i,
  input  logic        dbg_mode_i,
  input  sec_ctrl_t   sec_ctrl_i,
  // Fetch responses
  output logic        resp_valid_o,
  output instr_resp_t resp_o,
  output logic        alert_major_o,
  // OBI bus
  output logic        obi_req_o,
  output logic        obi_reqpar_o,
  output obi_a_t      obi_a_o,
  input  logic        obi_gnt_i,
  input  logic        obi_gntpar_i,
  input  logic        obi_rvalid_i,
  input  logic        obi_rvalidpar_i,
  input  obi_r_t      obi_r_i
);

  logic   trans_valid;
  logic   trans_ready;
  obi_a_t trans;

  // Response strobe also returns credits to the generator
  fetch_addr_gen #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) u_fetch_addr_gen (
    .clk             (clk),
    .rst_n           (rst_n),
    .fetch_en_i      (fetch_en_i),
    .redirect_i      (redirect_i),
    .redirect_addr_i (redirect_addr_i),
    .dbg_mode_i      (dbg_mode_i),
    .trans_valid_o   (trans_valid),
    .trans_ready_i   (trans_ready),
    .trans_o         (trans),
    .resp_valid_i    (resp_valid_o)
  );

  instr_obi_adapter #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) u_instr_obi_adapter (
    .clk             (clk),
    .rst_n           (rst_n),
    .trans_valid_i   (trans_valid),
    .trans_ready_o   (trans_ready),
    .trans_i         (trans),
    .resp_valid_o    (resp_valid_o),
    .resp_o          (resp_o),
    .alert_major_o   (alert_major_o),
    .sec_ctrl_i      (sec_ctrl_i),
    .obi_req_o       (obi_req_o),
    .obi_reqpar_o    (obi_reqpar_o),
    .obi_a_o         (obi_a_o),
    .obi_gnt_i       (obi_gnt_i),
    .obi_gntpar_i    (obi_gntpar_i),
    .obi_rvalid_i    (obi_rvalid_i),
    .obi_rvalidpar_i (obi_rvalidpar_i),
    .obi_r_i         (obi_r_i)
  );

endmodule

//--- dv/instr_obi_properties.sv
//////////////////////////////////////////////////
// OBI A channel protocol checks, bound into the top
// Checks hold only outside reset
//////////////////////////////////////////////////
`timescale 1ns/100ps

module instr_obi_properties import obi_bus_pkg::*; (
  input logic   clk,
  input logic   rst_n,
  input logic   obi_req_o,
  input logic   obi_reqpar_o,
  input obi_a_t obi_a_o,
  input logic   obi_gnt_i
);

  // Expected achk from the bus checksum rule
  function automatic logic [5:0] achk_rule(input obi_a_t a);
    logic [31:0] w;
    w = {a.addr[31:2], 2'b00};
    return {1'b1, ~^{a.prot, a.dbg}, ^w[31:24], ^w[23:16], ^w[15:8], ^w[7:0]};
  endfunction

  // Ungranted request keeps req high and the payload frozen
  a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
    obi_req_o && !obi_gnt_i |=> obi_req_o && $stable(obi_a_o))
    else $error("A channel changed while waiting for gnt");

  a_reqpar: assert property (@(posedge clk) disable iff (!rst_n)
    obi_reqpar_o == !obi_req_o)
    else $error("req parity twin is not the inverse of req");

  a_achk: assert property (@(posedge clk) disable iff (!rst_n)
    obi_req_o |-> obi_a_o.achk == achk_rule(obi_a_o))
    else $error("achk does not match the address phase");

endmodule

//--- dv/tb_instr_fetch_obi.sv
//////////////////////////////////////////////////
// Testbench for the OBI instruction fetch unit
// Random slave, in-order responses, fixed seed
// Spurious rvalid test runs last since it upsets the credit count
//////////////////////////////////////////////////
`timescale 1ns/100ps

module tb_instr_fetch_obi import obi_bus_pkg::*, obi_sec_pkg::*;;

  localparam int          MAX_OUT     = 2;
  localparam logic [31:0] DATA_KEY    = 32'hA5A5_5A5A;
  // Expected prot for a machine mode instruction fetch
  localparam logic [2:0]  PROT_EXP    = 3'b110;
  localparam int          M_CLEAN     = 0;
  localparam int          M_RCHK      = 1;
  localparam int          M_GPAR      = 2;
  localparam int          M_DRAIN     = 3;
  localparam int          TEST_CYCLES = 400 + 300 + 300 + 100 + 10;
  localparam int          WATCHDOG_NS = TEST_CYCLES * 3 / 2 * 10;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        fetch_en_i;
  logic        redirect_i;
  logic [31:0] redirect_addr_i;
  logic        dbg_mode_i;
  sec_ctrl_t   sec_ctrl_i;
  logic        resp_valid_o;
  instr_resp_t resp_o;
  logic        alert_major_o;
  logic        obi_req_o;
  logic        obi_reqpar_o;
  obi_a_t      obi_a_o;
  logic        obi_gnt_i;
  logic        obi_gntpar_i;
  logic        obi_rvalid_i;
  logic        obi_rvalidpar_i;
  obi_r_t      obi_r_i;

  // Slave and reference state
  logic [31:0] slv_q[$];
  logic [31:0] ref_addr_q[$];
  logic        ref_gpe_q[$];
  logic [31:0] exp_addr;
  logic        redir_pend;
  logic [31:0] redir_tgt;
  int          n_stale;
  // Control inputs applied at the next drive point
  logic        fetch_en_nxt;
  logic        dbg_nxt;
  // Request seen ungranted at the last sample and its debug flag
  logic        a_held;
  logic        a_dbg;
  int          n_errors;
  int          n_checks;
  int          n_tests;
  int          max_out;
  int          n_rchk_in;
  int          n_rchk_out;
  int          n_gpe_resp;

  always #5 clk = ~clk;

  instr_fetch_obi_top #(.MAX_OUTSTANDING(MAX_OUT)) DUT (.*);

  bind instr_fetch_obi_top instr_obi_properties u_obi_props (
    .clk(clk), .rst_n(rst_n), .obi_req_o(obi_req_o), .obi_reqpar_o(obi_reqpar_o),
    .obi_a_o(obi_a_o), .obi_gnt_i(obi_gnt_i));

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the tests did not finish in the expected time");
    $display("** FAIL **");
    $finish;
  end

  ////////////////////////////////////////////////////
  // Reference rules
  ////////////////////////////////////////////////////

  function automatic logic [5:0] achk_rule(input logic [31:0] a, input logic [2:0] p,
                                           input logic d);
    logic [31:0] w;
    w = {a[31:2], 2'b00};
    return {1'b1, ~^{p, d}, ^w[31:24], ^w[23:16], ^w[15:8], ^w[7:0]};
  endfunction

  function automatic logic [4:0] rchk_rule(input logic [31:0] d, input logic e);
    return {e, ^d[31:24], ^d[23:16], ^d[15:8], ^d[7:0]};
  endfunction

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    n_checks++;
    assert (got === exp) else begin
      $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
      n_errors++;
    end
  endtask

  task automatic expect_true(input logic ok, input string msg);
    n_checks++;
    assert (ok) else begin
      $display("Error at t=%0t: %s", $time, msg);
      n_errors++;
    end
  endtask

  ////////////////////////////////////////////////////
  // One bus cycle that drives after the edge and samples at negedge
  ////////////////////////////////////////////////////

  task automatic bus_cycle(input int mode, input logic spurious);
    logic        gnt;
    logic        gpe;
    logic        rv;
    logic        rerr;
    logic        rinj;
    logic        gpe_e;
    logic        bad;
    logic        alert_exp;
    logic        proto;
    logic [31:0] ra;
    logic [31:0] ea;
    @(posedge clk);
    #1;
    fetch_en_i = fetch_en_nxt;
    dbg_mode_i = dbg_nxt;
    gnt  = (mode != M_DRAIN || !spurious) && ($urandom % 4 != 0);
    gpe  = (mode == M_GPAR) && gnt && ($urandom % 8 == 0);
    rv   = spurious || ((slv_q.size() > 0) && ($urandom % 2 == 0));
    rerr = rv && ($urandom % 16 == 0);
    rinj = rv && !spurious && (mode == M_RCHK) && ($urandom % 4 == 0);
    ra   = (slv_q.size() > 0) ? slv_q[0] : $urandom;
    obi_gnt_i       = gnt;
    obi_gntpar_i    = gpe ? gnt : !gnt;
    obi_rvalid_i    = rv;
    obi_rvalidpar_i = !rv;
    obi_r_i.rdata   = ra ^ DATA_KEY;
    obi_r_i.err     = rerr;
    obi_r_i.rchk    = rchk_rule(ra ^ DATA_KEY, rerr) ^ (rinj ? 5'(1 << ($urandom % 5)) : 5'd0);
    redirect_i      = fetch_en_i && !redir_pend && (mode != M_DRAIN) && ($urandom % 40 == 0);
    redirect_addr_i = $urandom & 32'hFFFF_FFFC;
    @(negedge clk);
    proto = rv && (slv_q.size() == 0);
    bad   = rinj && ra[31] && sec_ctrl_i.integrity_en;
    alert_exp = gpe || proto || bad;
    check_val("alert_major_o", 32'(alert_major_o), 32'(alert_exp));
    check_val("resp_valid_o", 32'(resp_valid_o), 32'(rv));
    // Responses retire the oldest transfer first
    if (rv && !proto) begin
      gpe_e = ref_gpe_q.pop_front();
      ea    = ref_addr_q.pop_front();
      check_val("resp_o.rdata", resp_o.rdata, ea ^ DATA_KEY);
      check_val("resp_o.err", 32'(resp_o.err), 32'(rerr));
      check_val("resp_o.integrity_err", 32'(resp_o.integrity_err), 32'(gpe_e || bad));
      check_val("resp_o.integrity", 32'(resp_o.integrity), 32'(ea[31]));
      if (rinj && ra[31]) n_rchk_in++;
      if (rinj && !ra[31]) n_rchk_out++;
      if (gpe_e) n_gpe_resp++;
      void'(slv_q.pop_front());
    end
    // A new request takes the debug mode of its first cycle
    if (obi_req_o && !a_held) a_dbg = dbg_mode_i;
    // Granted addresses must follow the fetch order
    if (obi_req_o && gnt) begin
      check_val("obi_a_o.achk", 32'(obi_a_o.achk),
                32'(achk_rule(obi_a_o.addr, obi_a_o.prot, obi_a_o.dbg)));
      check_val("obi_a_o.prot", 32'(obi_a_o.prot), 32'(PROT_EXP));
      check_val("obi_a_o.dbg", 32'(obi_a_o.dbg), 32'(a_dbg));
      if (redir_pend && obi_a_o.addr == redir_tgt) begin
        redir_pend = 1'b0;
        ref_addr_q.push_back(redir_tgt);
        exp_addr   = redir_tgt + 32'd4;
      end else begin
        check_val("obi_a_o.addr", obi_a_o.addr, exp_addr);
        // At most the held and the parked request precede the target
        if (redir_pend) begin
          n_stale++;
          expect_true(n_stale <= 2, "redirect target not fetched after the older requests");
        end
        ref_addr_q.push_back(exp_addr);
        exp_addr = exp_addr + 32'd4;
      end
      slv_q.push_back(obi_a_o.addr);
      ref_gpe_q.push_back(gpe);
    end
    a_held = obi_req_o && !gnt;
    if (redirect_i) begin
      redir_pend = 1'b1;
      redir_tgt  = redirect_addr_i;
      n_stale    = 0;
    end
    if (slv_q.size() > max_out) max_out = slv_q.size();
    expect_true(slv_q.size() <= MAX_OUT, "more granted transfers outstanding than allowed");
  endtask

  task automatic run_test(input string name, input int mode, input int cycles);
    int start_err;
    start_err = n_errors;
    for (int i = 0; i < cycles; i++) bus_cycle(mode, 1'b0);
    report_test(name, start_err);
  endtask

  task automatic report_test(input string name, input int start_err);
    n_tests++;
    $display("Test %0d %s: %s", n_tests, name,
             (n_errors == start_err) ? "passed" : "failed");
  endtask

  ////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////

  initial begin
    int start_err;
    void'($urandom(54));
    rst_n           = 1'b0;
    fetch_en_i      = 1'b0;
    fetch_en_nxt    = 1'b1;
    redirect_i      = 1'b0;
    redirect_addr_i = 32'h0;
    dbg_mode_i      = 1'b0;
    dbg_nxt         = 1'b0;
    sec_ctrl_i      = '{integrity_en: 1'b1, parity_en: 1'b1};
    obi_gnt_i       = 1'b0;
    obi_gntpar_i    = 1'b1;
    obi_rvalid_i    = 1'b0;
    obi_rvalidpar_i = 1'b1;
    obi_r_i         = '0;
    exp_addr        = 32'h0;
    redir_pend      = 1'b0;
    redir_tgt       = 32'h0;
    n_stale         = 0;
    a_held          = 1'b0;
    a_dbg           = 1'b0;
    {n_errors, n_checks, n_tests, max_out} = '0;
    {n_rchk_in, n_rchk_out, n_gpe_resp} = '0;
    repeat (3) @(posedge clk);
    #1 rst_n = 1'b1;
    fetch_en_i = 1'b1;
    run_test("sequential fetch with redirects and gnt stalls", M_CLEAN, 400);
    dbg_nxt = 1'b1;
    run_test("rchk corruption in and out of the integrity region", M_RCHK, 300);
    expect_true(n_rchk_in > 0 && n_rchk_out > 0, "rchk faults did not hit both regions");
    dbg_nxt = 1'b0;
    run_test("gnt parity fault flagged on its response", M_GPAR, 300);
    expect_true(n_gpe_resp > 0, "no response carried a gnt parity fault");
    start_err = n_errors;
    expect_true(max_out == MAX_OUT, "outstanding transfers did not stop at the credit limit");
    report_test("credit limit on outstanding transfers", start_err);
    // Drain all traffic and then answer with nothing outstanding
    start_err    = n_errors;
    fetch_en_nxt = 1'b0;
    for (int i = 0; i < 100 && (i == 0 || slv_q.size() > 0 || obi_req_o); i++) begin
      bus_cycle(M_DRAIN, 1'b0);
    end
    expect_true(slv_q.size() == 0 && !obi_req_o, "bus did not drain with fetch disabled");
    bus_cycle(M_DRAIN, 1'b1);
    report_test("rvalid with nothing outstanding", start_err);
    $display("Tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- all.f
logic/obi_sec_pkg.sv
logic/obi_bus_pkg.sv
logic/fetch_addr_gen.sv
logic/obi_integrity_fifo.sv
logic/instr_obi_adapter.sv
logic/instr_fetch_obi_top.sv
dv/instr_obi_properties.sv
dv/tb_instr_fetch_obi.sv

//--- run.sh
#!/bin/sh
# Build and run the fetch unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f all.f \
  --top-module tb_instr_fetch_obi -o tb_sim \
  && ./obj_dir/tb_sim | tee /dev/stderr | grep -qF '** PASS **' \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
